/* sim/soc_tests.txt */
# op addr wdata strb expect, hex, - where unused, rand for an lfsr word
# W write, R read, P poll read (wdata=cycle bound), D wait (wdata=cycles), I irpt, J poll irpt, S/M/C mtime
W 00000000 11223344 f -
W 00000000 aabbccdd 5 -
W 00000000 55667788 a -
R 00000000 - 0 55bb77dd
W 00000400 cafef00d 3 -
R 00000000 - 0 55bbf00d
W 00000004 rand f -
R 00000404 - 0 rand
R 00000c04 - 0 rand
W 00000008 0bad0bad f -
W 10000008 12345678 f -
W 20000008 f00dfeed f -
R 00000008 - 0 0bad0bad
R 20000008 - 0 f00dfeed
W 10000000 000000a5 1 -
R 10000004 - 0 00000001
P 10000004 c8 0 00000002
R 10000000 - 0 000000a5
R 10000004 - 0 00000000
S 20000000 - 0 -
D - 12c 0 -
M 20000000 - 0 -
W 2000000c 00000000 f -
I - - 0 0
S 20000000 - 0 -
C 20000008 4 f -
I - - 0 0
J - c8 0 1
W 2000000c ffffffff f -
I - - 0 0

/* list.f */
common/soc_pkg.sv
hdl/mem_decode.sv
hdl/bram.sv
uart/uart.sv
timer/timer.sv
hdl/soc_top.sv
sim/soc_tb.sv

/* run.sh */
#!/bin/sh
# build the soc testbench with verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module soc_tb -o soc_sim || exit 1
./obj_dir/soc_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb import soc_pkg::*; ();

  localparam int unsigned reset_cycles    = 10;
  localparam int unsigned cycles_per_test = 400;
  localparam int unsigned ready_limit     = 16;  // give up on a missing mem_ready
  localparam string       tests_file      = "sim/soc_tests.txt";

  logic                  clk;
  logic                  rst_n;
  logic                  mem_valid;
  logic [bus_addr_w-1:0] mem_addr;
  logic [bus_data_w-1:0] mem_wdata;
  logic [bus_strb_w-1:0] mem_wstrb;
  logic [bus_data_w-1:0] mem_rdata;
  logic                  mem_ready;
  logic                  serial;  // tx looped back to rx
  logic                  timer_irpt;

  string       lines[$];
  int unsigned n_tests;
  int unsigned pass_count;
  int unsigned fail_count;
  int unsigned line_errors;
  int unsigned cycle_cnt;
  int unsigned snap_cycle;
  logic [31:0] snap_value;
  logic [31:0] last_rand;
  logic [31:0] lfsr;

  soc_top soc_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .rx         (serial),
    .mem_rdata  (mem_rdata),
    .mem_ready  (mem_ready),
    .tx         (serial),
    .timer_irpt (timer_irpt)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // ==============================
  // helpers
  // ==============================
  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = next_lfsr(lfsr);  // one step per bit
      word = {word[30:0], lfsr[0]};
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expect_v,
                             input logic [31:0] got);
    assert (got === expect_v) else begin
      $display("FAIL %0t %s expected %08h got %08h", $time, name, expect_v, got);
      line_errors++;
    end
  endtask

  task automatic bus_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata);
    int unsigned wait_cycles;
    @(posedge clk);
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wdata <= wdata;
    mem_wstrb <= strb;
    wait_cycles = 0;
    @(negedge clk);  // ready is still low in the cycle valid rises
    while (!mem_ready && wait_cycles < ready_limit) begin
      @(negedge clk);
      wait_cycles++;
    end
    rdata = mem_rdata;
    if (!mem_ready) begin
      $display("no mem_ready within %0d cycles for address %08h", ready_limit, addr);
      line_errors++;
    end else begin
      assert (wait_cycles == 1) else begin
        $display("FAIL %0t mem_ready latency expected 1 got %0d", $time, wait_cycles);
        line_errors++;
      end
    end
    @(posedge clk);
    mem_valid <= 1'b0;
    mem_wstrb <= '0;
  endtask

  task automatic poll_read(input logic [31:0] addr, input int unsigned bound,
                           input logic [31:0] expect_v);
    int unsigned start;
    logic [31:0] got;
    start = cycle_cnt;
    bus_transfer(addr, '0, '0, got);
    while (got !== expect_v && cycle_cnt - start < bound) begin
      bus_transfer(addr, '0, '0, got);
    end
    assert (got === expect_v) else begin
      $display("value %08h never arrived at %08h within %0d cycles, last read %08h",
               expect_v, addr, bound, got);
      line_errors++;
    end
  endtask

  task automatic await_irpt(input int unsigned bound, input logic level);
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (timer_irpt !== level && n < bound) begin
      @(negedge clk);
      n++;
    end
    assert (timer_irpt === level) else begin
      $display("timer_irpt never reached %0b within %0d cycles", level, bound);
      line_errors++;
    end
  endtask

  task automatic load_tests();
    int    fd;
    string line;
    fd = $fopen(tests_file, "r");
    if (fd == 0) begin
      $display("could not open %s", tests_file);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    n_tests = lines.size();
  endtask

  // ==============================
  // one line of the test file
  // ==============================
  task automatic run_test(input int unsigned num, input string line);
    string       op;
    string       a_s;
    string       d_s;
    string       s_s;
    string       e_s;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expect_v;
    logic [31:0] got;
    logic [3:0]  strb;
    int          fields;
    int unsigned elapsed;
    int unsigned min_inc;
    line_errors = 0;
    fields = $sscanf(line, "%s %s %s %s %s", op, a_s, d_s, s_s, e_s);
    if (fields != 5) begin
      $display("test %0d does not have five columns", num);
      line_errors++;
    end else begin
      addr = a_s.atohex();
      strb = 4'(s_s.atohex());
      data = (d_s == "rand") ? random_word() : d_s.atohex();
      if (d_s == "rand") begin
        last_rand = data;
      end
      expect_v = (e_s == "rand") ? last_rand : e_s.atohex();
      if (op == "W") begin
        bus_transfer(addr, data, strb, got);
      end else if (op == "R") begin
        bus_transfer(addr, '0, '0, got);
        check_value("mem_rdata", expect_v, got);
      end else if (op == "P") begin
        poll_read(addr, data, expect_v);
      end else if (op == "D") begin
        repeat (data) @(posedge clk);
      end else if (op == "I") begin
        @(negedge clk);
        check_value("timer_irpt", expect_v, {31'b0, timer_irpt});
      end else if (op == "J") begin
        await_irpt(data, expect_v[0]);
      end else if (op == "S") begin
        bus_transfer(addr, '0, '0, got);
        snap_value = got;
        snap_cycle = cycle_cnt;
      end else if (op == "M") begin
        bus_transfer(addr, '0, '0, got);
        elapsed = cycle_cnt - snap_cycle;
        min_inc = elapsed / rtc_divider;  // whole tick periods in the wait
        assert (got - snap_value + 1 >= min_inc) else begin
          $display("FAIL %0t mtime increase expected at least %0d got %0d",
                   $time, min_inc - 1, got - snap_value);
          line_errors++;
        end
      end else if (op == "C") begin
        bus_transfer(addr, snap_value + data, strb, got);
      end else begin
        $display("test %0d has an unknown operation %s", num, op);
        line_errors++;
      end
    end
    if (line_errors == 0) begin
      pass_count++;
      $display("PASS test %0d: %s %s", num, op, a_s);
    end else begin
      fail_count++;
      $display("FAIL test %0d: %s %s", num, op, a_s);
    end
  endtask

  // ==============================
  // runner and watchdog
  // ==============================
  initial begin
    rst_n      = 1'b0;
    mem_valid  = 1'b0;
    mem_addr   = '0;
    mem_wdata  = '0;
    mem_wstrb  = '0;
    lfsr       = 32'h5546_d7b5;
    last_rand  = '0;
    snap_value = '0;
    snap_cycle = 0;
    n_tests    = 0;
    pass_count = 0;
    fail_count = 0;
    load_tests();
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < lines.size(); i++) begin
      run_test(i, lines[i]);
    end
    $display("%0d tests run, %0d passed, %0d failed", n_tests, pass_count, fail_count);
    if (fail_count == 0 && n_tests > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (n_tests > 0);
    repeat (n_tests * cycles_per_test + reset_cycles) @(posedge clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* hdl/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  mem_valid,
  input  logic [bus_addr_w-1:0] mem_addr,
  input  logic [bus_data_w-1:0] mem_wdata,
  input  logic [bus_strb_w-1:0] mem_wstrb,
  input  logic                  rx,
  output logic [bus_data_w-1:0] mem_rdata,
  output logic                  mem_ready,
  output logic                  tx,
  output logic                  timer_irpt
);

  logic [rtc_cnt_w-1:0]  rtc_cnt;
  logic                  rtc_tick;

  logic                  bram_valid;
  logic [bus_data_w-1:0] bram_rdata;
  logic                  bram_ready;
  logic                  uart_valid;
  logic [bus_data_w-1:0] uart_rdata;
  logic                  uart_ready;
  logic                  timer_valid;
  logic [bus_data_w-1:0] timer_rdata;
  logic                  timer_ready;
  logic [bus_addr_w-1:0] slave_addr;

  // ==============================
  // rtc tick
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_cnt  <= '0;
      rtc_tick <= 1'b0;
    end else if (rtc_cnt == rtc_last) begin
      rtc_cnt  <= '0;
      rtc_tick <= 1'b1;  // one clk wide
    end else begin
      rtc_cnt  <= rtc_cnt + 1'b1;
      rtc_tick <= 1'b0;
    end
  end

  // ==============================
  // fabric
  // ==============================
  mem_decode decode_i (
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .bram_rdata  (bram_rdata),
    .bram_ready  (bram_ready),
    .uart_rdata  (uart_rdata),
    .uart_ready  (uart_ready),
    .timer_rdata (timer_rdata),
    .timer_ready (timer_ready),
    .mem_rdata   (mem_rdata),
    .mem_ready   (mem_ready),
    .bram_valid  (bram_valid),
    .uart_valid  (uart_valid),
    .timer_valid (timer_valid),
    .slave_addr  (slave_addr)
  );

  bram bram_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .bram_valid (bram_valid),
    .addr       (slave_addr),
    .wdata      (mem_wdata),
    .wstrb      (mem_wstrb),
    .rdata      (bram_rdata),
    .ready      (bram_ready)
  );

  uart uart_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .uart_valid (uart_valid),
    .addr       (slave_addr),
    .wdata      (mem_wdata),
    .wstrb      (mem_wstrb),
    .rx         (rx),
    .rdata      (uart_rdata),
    .ready      (uart_ready),
    .tx         (tx)
  );

  timer timer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .timer_valid (timer_valid),
    .addr        (slave_addr),
    .wdata       (mem_wdata),
    .wstrb       (mem_wstrb),
    .rtc_tick    (rtc_tick),
    .rdata       (timer_rdata),
    .ready       (timer_ready),
    .timer_irpt  (timer_irpt)
  );

endmodule

/* timer/timer.sv */
`timescale 1ns/1ps

module timer import soc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  timer_valid,
  input  logic [bus_addr_w-1:0] addr,
  input  logic [bus_data_w-1:0] wdata,
  input  logic [bus_strb_w-1:0] wstrb,
  input  logic                  rtc_tick,
  output logic [bus_data_w-1:0] rdata,
  output logic                  ready,
  output logic                  timer_irpt
);

  function automatic logic [bus_data_w-1:0] merge_bytes(
    input logic [bus_data_w-1:0] old_w,
    input logic [bus_data_w-1:0] new_w,
    input logic [bus_strb_w-1:0] strb
  );
    logic [bus_data_w-1:0] res;
    res = old_w;
    for (int b = 0; b < bus_strb_w; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  logic        access;
  logic        wr;
  logic        rd;
  logic [63:0] mtime;
  logic [63:0] mtime_nxt;
  logic [63:0] mtimecmp;

  assign access = timer_valid && !ready;
  assign wr     = access && (wstrb != '0);
  assign rd     = access && (wstrb == '0);

  // ==============================
  // registers
  // ==============================
  always_comb begin
    mtime_nxt = mtime + 64'(rtc_tick);
    if (wr && addr == timer_reg_time_lo) begin
      mtime_nxt[31:0] = merge_bytes(mtime[31:0], wdata, wstrb);  // bus write beats the tick
    end
    if (wr && addr == timer_reg_time_hi) begin
      mtime_nxt[63:32] = merge_bytes(mtime[63:32], wdata, wstrb);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtime    <= '0;
      mtimecmp <= '1;  // keeps irpt low out of reset
      ready    <= 1'b0;
    end else begin
      mtime <= mtime_nxt;
      ready <= access;
      if (wr && addr == timer_reg_cmp_lo) begin
        mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], wdata, wstrb);
      end
      if (wr && addr == timer_reg_cmp_hi) begin
        mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], wdata, wstrb);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      case (addr)
        timer_reg_time_lo: rdata <= mtime[31:0];
        timer_reg_time_hi: rdata <= mtime[63:32];
        timer_reg_cmp_lo:  rdata <= mtimecmp[31:0];
        timer_reg_cmp_hi:  rdata <= mtimecmp[63:32];
        default:           rdata <= '0;
      endcase
    end else if (wr) begin
      rdata <= '0;
    end
  end

  assign timer_irpt = (mtime >= mtimecmp);

endmodule

/* uart/uart.sv */
`timescale 1ns/1ps

module uart import soc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  uart_valid,
  input  logic [bus_addr_w-1:0] addr,
  input  logic [bus_data_w-1:0] wdata,
  input  logic [bus_strb_w-1:0] wstrb,
  input  logic                  rx,
  output logic [bus_data_w-1:0] rdata,
  output logic                  ready,
  output logic                  tx
);

  logic access;
  logic wr;
  logic rd;
  logic tx_load;
  logic rd_clear;

  logic [9:0]            tx_shift;  // stop, data, start
  logic [3:0]            tx_bits;
  logic [uart_cnt_w-1:0] tx_cnt;
  logic                  tx_busy;

  logic [1:0]            rx_sync;
  logic                  rx_in;
  logic                  rx_busy;
  logic [uart_cnt_w-1:0] rx_cnt;
  logic [3:0]            rx_bits;
  logic [7:0]            rx_shift;
  logic [7:0]            rx_data;
  logic                  rx_full;
  logic                  rx_tick;
  logic                  rx_done;

  assign access   = uart_valid && !ready;
  assign wr       = access && (wstrb != '0);
  assign rd       = access && (wstrb == '0);
  assign tx_load  = wr && wstrb[0] && (addr == uart_reg_data) && !tx_busy;  // busy drops it
  assign rd_clear = rd && (addr == uart_reg_data);

  // ==============================
  // bus side
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      case (addr)
        uart_reg_data:   rdata <= {{(bus_data_w-8){1'b0}}, rx_data};
        uart_reg_status: rdata <= {{(bus_data_w-2){1'b0}}, rx_full, tx_busy};
        default:         rdata <= '0;
      endcase
    end else if (wr) begin
      rdata <= '0;
    end
  end

  // ==============================
  // transmitter
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '1;
      tx_bits  <= '0;
      tx_cnt   <= '0;
      tx_busy  <= 1'b0;
    end else if (!tx_busy) begin
      if (tx_load) begin
        tx_shift <= {1'b1, wdata[7:0], 1'b0};
        tx_bits  <= '0;
        tx_cnt   <= '0;
        tx_busy  <= 1'b1;
      end
    end else if (tx_cnt == uart_bit_last) begin
      tx_cnt   <= '0;
      tx_shift <= {1'b1, tx_shift[9:1]};  // lsb first
      if (tx_bits == 4'd9) begin
        tx_busy <= 1'b0;
      end else begin
        tx_bits <= tx_bits + 4'd1;
      end
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  assign tx = tx_shift[0];

  // ==============================
  // receiver
  // ==============================
  assign rx_in   = rx_sync[1];
  assign rx_tick = rx_busy && (rx_cnt == uart_bit_last);  // mid-bit sample point
  assign rx_done = rx_tick && (rx_bits == 4'd9) && rx_in;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
      rx_busy <= 1'b0;
      rx_cnt  <= '0;
      rx_bits <= '0;
      rx_full <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      if (!rx_busy) begin
        if (!rx_in) begin
          rx_busy <= 1'b1;
          rx_cnt  <= uart_bit_half;  // first tick lands mid start bit
          rx_bits <= '0;
        end
      end else if (rx_tick) begin
        rx_cnt  <= '0;
        rx_bits <= rx_bits + 4'd1;
        if ((rx_bits == 4'd0 && rx_in) || rx_bits == 4'd9) begin
          rx_busy <= 1'b0;  // false start or frame end
        end
      end else begin
        rx_cnt <= rx_cnt + 1'b1;
      end
      if (rx_done) begin
        rx_full <= 1'b1;
      end else if (rd_clear) begin
        rx_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_tick && rx_bits != 4'd0 && rx_bits != 4'd9) begin
      rx_shift <= {rx_in, rx_shift[7:1]};
    end
    if (rx_done) begin
      rx_data <= rx_shift;
    end
  end

endmodule

/* hdl/bram.sv */
`timescale 1ns/1ps

module bram import soc_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bram_valid,
  input  logic [bus_addr_w-1:0] addr,
  input  logic [bus_data_w-1:0] wdata,
  input  logic [bus_strb_w-1:0] wstrb,
  output logic [bus_data_w-1:0] rdata,
  output logic                  ready
);

  logic [bus_data_w-1:0] mem [bram_words];

  logic                  access;
  logic [bram_idx_w-1:0] idx;

  // valid is ignored while ready is out
  assign access = bram_valid && !ready;
  assign idx    = addr[bram_idx_w+1:2];  // modulo depth

  // ==============================
  // storage
  // ==============================
  always_ff @(posedge clk) begin
    if (access) begin
      for (int b = 0; b < bus_strb_w; b++) begin
        if (wstrb[b]) begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
      if (wstrb == '0) begin
        rdata <= mem[idx];
      end else begin
        rdata <= '0;  // writes return nothing
      end
    end
  end

  // ==============================
  // handshake
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;  // single cycle pulse
    end
  end

endmodule

/* hdl/mem_decode.sv */
`timescale 1ns/1ps

module mem_decode import soc_pkg::*; (
  input  logic                  mem_valid,
  input  logic [bus_addr_w-1:0] mem_addr,
  input  logic [bus_data_w-1:0] bram_rdata,
  input  logic                  bram_ready,
  input  logic [bus_data_w-1:0] uart_rdata,
  input  logic                  uart_ready,
  input  logic [bus_data_w-1:0] timer_rdata,
  input  logic                  timer_ready,
  output logic [bus_data_w-1:0] mem_rdata,
  output logic                  mem_ready,
  output logic                  bram_valid,
  output logic                  uart_valid,
  output logic                  timer_valid,
  output logic [bus_addr_w-1:0] slave_addr
);

  logic uart_hit;
  logic timer_hit;

  assign uart_hit  = (mem_addr >= uart_base_addr) &&
                     (mem_addr < uart_base_addr + uart_size);
  assign timer_hit = (mem_addr >= timer_base_addr) &&
                     (mem_addr < timer_base_addr + timer_size);

  // ==============================
  // request side
  // ==============================
  always_comb begin
    bram_valid  = 1'b0;
    uart_valid  = 1'b0;
    timer_valid = 1'b0;
    slave_addr  = mem_addr;  // bram aliases everything else
    if (uart_hit) begin
      uart_valid = mem_valid;
      slave_addr = mem_addr - uart_base_addr;
    end else if (timer_hit) begin
      timer_valid = mem_valid;
      slave_addr  = mem_addr - timer_base_addr;
    end else begin
      bram_valid = mem_valid;
    end
  end

  // ==============================
  // response side
  // ==============================
  always_comb begin
    if (bram_ready) begin
      mem_rdata = bram_rdata;
      mem_ready = 1'b1;
    end else if (uart_ready) begin
      mem_rdata = uart_rdata;
      mem_ready = 1'b1;
    end else if (timer_ready) begin
      mem_rdata = timer_rdata;
      mem_ready = 1'b1;
    end else begin
      mem_rdata = '0;
      mem_ready = 1'b0;
    end
  end

endmodule

/* common/soc_pkg.sv */
package soc_pkg;

  // ==============================
  // bus geometry
  // ==============================
  localparam int unsigned bus_data_w = 32;
  localparam int unsigned bus_addr_w = 32;
  localparam int unsigned bus_strb_w = bus_data_w / 8;

  localparam int unsigned bram_words = 256;
  localparam int unsigned bram_idx_w = $clog2(bram_words);  // word index bits

  // ==============================
  // address map
  // ==============================
  localparam logic [bus_addr_w-1:0] uart_base_addr  = 32'h1000_0000;
  localparam logic [bus_addr_w-1:0] uart_size       = 32'h0000_0010;
  localparam logic [bus_addr_w-1:0] timer_base_addr = 32'h2000_0000;
  localparam logic [bus_addr_w-1:0] timer_size      = 32'h0000_0010;

  localparam logic [bus_addr_w-1:0] uart_reg_data   = 32'h0;
  localparam logic [bus_addr_w-1:0] uart_reg_status = 32'h4;

  localparam logic [bus_addr_w-1:0] timer_reg_time_lo = 32'h0;
  localparam logic [bus_addr_w-1:0] timer_reg_time_hi = 32'h4;
  localparam logic [bus_addr_w-1:0] timer_reg_cmp_lo  = 32'h8;
  localparam logic [bus_addr_w-1:0] timer_reg_cmp_hi  = 32'hc;

  // ==============================
  // dividers
  // ==============================
  localparam int unsigned uart_clks_per_bit = 16;
  localparam int unsigned uart_cnt_w = $clog2(uart_clks_per_bit);
  localparam logic [uart_cnt_w-1:0] uart_bit_last = uart_cnt_w'(uart_clks_per_bit - 1);
  localparam logic [uart_cnt_w-1:0] uart_bit_half = uart_cnt_w'(uart_clks_per_bit / 2);

  localparam int unsigned rtc_divider = 8;
  localparam int unsigned rtc_cnt_w = $clog2(rtc_divider);
  localparam logic [rtc_cnt_w-1:0] rtc_last = rtc_cnt_w'(rtc_divider - 1);

endpackage
